// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    // ========================================
    // major opcodes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_system = 7'b1110011
    } opcode_e;

    // machine csr addresses
    typedef enum logic [11:0] {
        csr_addr_mstatus = 12'h300,
        csr_addr_mtvec   = 12'h305,
        csr_addr_mepc    = 12'h341,
        csr_addr_mcause  = 12'h342
    } csr_addr_e;

    // ========================================
    // alu funct3 / funct7
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load widths, stores use the first three
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // system
    localparam logic [2:0]  f3_priv    = 3'b000;
    localparam logic [2:0]  f3_csrrw   = 3'b001;
    localparam logic [2:0]  f3_csrrs   = 3'b010;
    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;

endpackage

// ==== rtl/idu_pkg.sv ====
package idu_pkg;

    import rv_isa_pkg::*;

    // ========================================
    // control field encodings
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_or,
        alu_and, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    typedef enum logic {
        src1_rs1, src1_pc
    } alu_src1_e;

    typedef enum logic [1:0] {
        src2_rs2, src2_imm, src2_four, src2_csr
    } alu_src2_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
    } branch_e;

    // target base for br_jump
    typedef enum logic [1:0] {
        jb_pc, jb_rs1, jb_csr
    } jump_base_e;

    typedef enum logic [2:0] {
        mem_none, mem_byte, mem_half, mem_word, mem_byte_u, mem_half_u
    } mem_size_e;

    typedef enum logic [1:0] {
        csr_mstatus, csr_mtvec, csr_mepc, csr_mcause
    } csr_idx_e;

    // ========================================
    // bundles
    typedef struct packed {
        alu_op_e    alu_op;
        alu_src1_e  alu_src1;
        alu_src2_e  alu_src2;
        branch_e    branch;
        jump_base_e jump_base;
        logic       write_gpr;
        logic       write_csr;
        logic       mem_to_reg;
        logic       write_mem;
        logic       csrrs;
        logic       csrrw;
        logic       ecall;
        logic       halt;
        logic       illegal;
        mem_size_e  mem_size;
        csr_idx_e   csr_idx;
    } idu_ctrl_t;

    typedef struct packed {
        logic                 gpr_wr;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      gpr_data;
        logic                 csr_wr;
        csr_idx_e             csr_idx;
        logic [xlen-1:0]      csr_data;
    } wb_req_t;

    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      inst;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      rs1_data;
        logic [xlen-1:0]      rs2_data;
        logic [xlen-1:0]      csr_data;
        idu_ctrl_t            ctrl;
    } idu_out_t;

endpackage

// ==== rtl/idu_decode.sv ====
`timescale 1ns/10ps

module idu_decode import rv_isa_pkg::*, idu_pkg::*; (
    input  logic [xlen-1:0]      inst,
    output logic [reg_idx_w-1:0] rd,
    output logic [reg_idx_w-1:0] rs1,
    output logic [reg_idx_w-1:0] rs2,
    output logic [xlen-1:0]      imm,
    output idu_ctrl_t            ctrl
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [6:0]      f7_eff;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e         alu_op;
    logic            alu_ok;
    csr_idx_e        csr_map_idx;
    logic            csr_hit;
    logic            rs1_used, rs2_used;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rd  = inst[11:7];
    assign rs1 = rs1_used ? inst[19:15] : '0;
    assign rs2 = rs2_used ? inst[24:20] : '0;

    // ========================================
    // immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // ========================================
    // alu op shared by op and op_imm
    // op_imm only looks at funct7 for shifts
    assign f7_eff = (opcode == opc_op || funct3 == f3_sll || funct3 == f3_sr) ? funct7 : f7_base;

    always_comb begin
        alu_ok = 1'b1;
        alu_op = alu_add;
        case ({f7_eff, funct3})
            {f7_base, f3_add}:  alu_op = alu_add;
            {f7_alt,  f3_add}:  alu_op = alu_sub;
            {f7_base, f3_sll}:  alu_op = alu_sll;
            {f7_base, f3_slt}:  alu_op = alu_slt;
            {f7_base, f3_sltu}: alu_op = alu_sltu;
            {f7_base, f3_xor}:  alu_op = alu_xor;
            {f7_base, f3_sr}:   alu_op = alu_srl;
            {f7_alt,  f3_sr}:   alu_op = alu_sra;
            {f7_base, f3_or}:   alu_op = alu_or;
            {f7_base, f3_and}:  alu_op = alu_and;
            default:            alu_ok = 1'b0;
        endcase
    end

    // csr address map
    always_comb begin
        csr_hit     = 1'b1;
        csr_map_idx = csr_mstatus;
        case (inst[31:20])
            csr_addr_mstatus: csr_map_idx = csr_mstatus;
            csr_addr_mtvec:   csr_map_idx = csr_mtvec;
            csr_addr_mepc:    csr_map_idx = csr_mepc;
            csr_addr_mcause:  csr_map_idx = csr_mcause;
            default:          csr_hit     = 1'b0;
        endcase
    end

    // ========================================
    // main decode
    always_comb begin
        ctrl     = '0;
        imm      = '0;
        rs1_used = 1'b1;
        rs2_used = 1'b0;
        case (opcode)
            opc_op: begin
                rs2_used       = 1'b1;
                ctrl.alu_op    = alu_op;
                ctrl.write_gpr = 1'b1;
                ctrl.illegal   = !alu_ok;
            end
            opc_op_imm: begin
                imm            = imm_i;
                ctrl.alu_op    = alu_op;
                ctrl.alu_src2  = src2_imm;
                ctrl.write_gpr = 1'b1;
                ctrl.illegal   = !alu_ok;
            end
            opc_lui, opc_auipc: begin
                // lui adds to x0
                rs1_used       = 1'b0;
                imm            = imm_u;
                ctrl.alu_src1  = (opcode == opc_auipc) ? src1_pc : src1_rs1;
                ctrl.alu_src2  = src2_imm;
                ctrl.write_gpr = 1'b1;
            end
            opc_jal, opc_jalr: begin
                rs1_used       = (opcode == opc_jalr);
                imm            = (opcode == opc_jalr) ? imm_i : imm_j;
                ctrl.alu_src1  = src1_pc;
                ctrl.alu_src2  = src2_four;
                ctrl.branch    = br_jump;
                ctrl.jump_base = (opcode == opc_jalr) ? jb_rs1 : jb_pc;
                ctrl.write_gpr = 1'b1;
                ctrl.illegal   = (opcode == opc_jalr) && (funct3 != 3'b000);
            end
            opc_branch: begin
                rs2_used = 1'b1;
                imm      = imm_b;
                case (funct3)
                    f3_beq:  ctrl.branch = br_eq;
                    f3_bne:  ctrl.branch = br_ne;
                    f3_blt:  ctrl.branch = br_lt;
                    f3_bge:  ctrl.branch = br_ge;
                    f3_bltu: ctrl.branch = br_ltu;
                    f3_bgeu: ctrl.branch = br_geu;
                    default: ctrl.illegal = 1'b1;
                endcase
                case (ctrl.branch)
                    br_eq, br_ne:   ctrl.alu_op = alu_sub;
                    br_lt, br_ge:   ctrl.alu_op = alu_slt;
                    br_ltu, br_geu: ctrl.alu_op = alu_sltu;
                    default:        ctrl.alu_op = alu_add;
                endcase
            end
            opc_load: begin
                imm           = imm_i;
                ctrl.alu_src2 = src2_imm;
                case (funct3)
                    f3_lb:   ctrl.mem_size = mem_byte;
                    f3_lh:   ctrl.mem_size = mem_half;
                    f3_lw:   ctrl.mem_size = mem_word;
                    f3_lbu:  ctrl.mem_size = mem_byte_u;
                    f3_lhu:  ctrl.mem_size = mem_half_u;
                    default: ctrl.illegal  = 1'b1;
                endcase
                ctrl.mem_to_reg = !ctrl.illegal;
                ctrl.write_gpr  = 1'b1;
            end
            opc_store: begin
                rs2_used      = 1'b1;
                imm           = imm_s;
                ctrl.alu_src2 = src2_imm;
                case (funct3)
                    f3_lb:   ctrl.mem_size = mem_byte;
                    f3_lh:   ctrl.mem_size = mem_half;
                    f3_lw:   ctrl.mem_size = mem_word;
                    default: ctrl.illegal  = 1'b1;
                endcase
                ctrl.write_mem = 1'b1;
            end
            opc_system: begin
                imm = imm_i;
                case (funct3)
                    f3_priv: begin
                        rs1_used = 1'b0;
                        if (inst[31:20] == f12_ecall) begin
                            // trap through mtvec
                            ctrl.ecall     = 1'b1;
                            ctrl.branch    = br_jump;
                            ctrl.jump_base = jb_csr;
                            ctrl.csr_idx   = csr_mtvec;
                        end else if (inst[31:20] == f12_ebreak) begin
                            ctrl.halt = 1'b1;
                        end else begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                    f3_csrrw, f3_csrrs: begin
                        ctrl.csrrw     = (funct3 == f3_csrrw);
                        ctrl.csrrs     = (funct3 == f3_csrrs);
                        ctrl.alu_op    = (funct3 == f3_csrrs) ? alu_or : alu_add;
                        ctrl.alu_src2  = src2_csr;
                        ctrl.csr_idx   = csr_map_idx;
                        ctrl.write_gpr = 1'b1;
                        ctrl.write_csr = 1'b1;
                        ctrl.illegal   = !csr_hit;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (ctrl.illegal) begin
            ctrl.write_gpr = 1'b0;
            ctrl.write_csr = 1'b0;
            ctrl.write_mem = 1'b0;
        end
    end

    // memory access needs a size
    always_comb begin
        assert ((!ctrl.write_mem && !ctrl.mem_to_reg) || ctrl.mem_size != mem_none);
    end

endmodule

// ==== rtl/idu_gpr_file.sv ====
`timescale 1ns/10ps

module idu_gpr_file import rv_isa_pkg::*, idu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [reg_idx_w-1:0] rs1,
    input  logic [reg_idx_w-1:0] rs2,
    input  wb_req_t              wb,
    output logic [xlen-1:0]      rs1_data,
    output logic [xlen-1:0]      rs2_data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.gpr_wr && wb.rd != '0) begin
            regs[wb.rd] <= wb.gpr_data;
        end
    end

    // read with write-back bypass
    function automatic logic [xlen-1:0] read_port(input logic [reg_idx_w-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.gpr_wr && wb.rd == idx) begin
            return wb.gpr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0));

endmodule

// ==== rtl/idu_csr_file.sv ====
`timescale 1ns/10ps

module idu_csr_file import rv_isa_pkg::*, idu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  csr_idx_e        csr_idx,
    input  wb_req_t         wb,
    output logic [xlen-1:0] csr_data
);

    // mstatus, mtvec, mepc, mcause
    logic [xlen-1:0] csr_q [4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= '0;
            end
        end else if (wb.csr_wr) begin
            csr_q[wb.csr_idx] <= wb.csr_data;
        end
    end

    assign csr_data = (wb.csr_wr && wb.csr_idx == csr_idx) ? wb.csr_data : csr_q[csr_idx];

    a_wr_idx_known: assert property (@(posedge clk) disable iff (!arst_n)
        wb.csr_wr |-> !$isunknown(wb.csr_idx));

endmodule

// ==== rtl/idu_stage_reg.sv ====
`timescale 1ns/10ps

module idu_stage_reg import rv_isa_pkg::*, idu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 commit,
    input  logic [xlen-1:0]      pc,
    input  logic [xlen-1:0]      inst,
    input  logic [reg_idx_w-1:0] rd,
    input  logic [reg_idx_w-1:0] rs1,
    input  logic [reg_idx_w-1:0] rs2,
    input  logic [xlen-1:0]      imm,
    input  logic [xlen-1:0]      rs1_data,
    input  logic [xlen-1:0]      rs2_data,
    input  logic [xlen-1:0]      csr_data,
    input  idu_ctrl_t            ctrl,
    output idu_out_t             out,
    output logic                 out_valid
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            // one-cycle pulse per commit
            out_valid <= commit;
            if (commit) begin
                out.pc       <= pc;
                out.inst     <= inst;
                out.rd       <= rd;
                out.rs1      <= rs1;
                out.rs2      <= rs2;
                out.imm      <= imm;
                out.rs1_data <= rs1_data;
                out.rs2_data <= rs2_data;
                out.csr_data <= csr_data;
                out.ctrl     <= ctrl;
            end
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !commit |=> $stable(out));

endmodule

// ==== rtl/idu_top.sv ====
`timescale 1ns/10ps

module idu_top import rv_isa_pkg::*, idu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] inst,
    input  logic            commit,
    input  wb_req_t         wb,
    output idu_out_t        out,
    output logic            out_valid
);

    logic [reg_idx_w-1:0] rd, rs1, rs2;
    logic [xlen-1:0]      imm;
    idu_ctrl_t            ctrl;
    logic [xlen-1:0]      rs1_data, rs2_data, csr_data;

    idu_decode idu_decode_inst (
        .inst (inst),
        .rd   (rd),
        .rs1  (rs1),
        .rs2  (rs2),
        .imm  (imm),
        .ctrl (ctrl)
    );

    idu_gpr_file idu_gpr_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    idu_csr_file idu_csr_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .csr_idx  (ctrl.csr_idx),
        .wb       (wb),
        .csr_data (csr_data)
    );

    idu_stage_reg idu_stage_reg_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .commit    (commit),
        .pc        (pc),
        .inst      (inst),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_data  (csr_data),
        .ctrl      (ctrl),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

// ==== tb/idu_tb.sv ====
`timescale 1ns/10ps

module idu_tb import rv_isa_pkg::*, idu_pkg::*; ();

    localparam int total_cycles = 300;
    localparam int timeout_ns   = total_cycles * 10 + 2000;

    logic            clk = 1'b0;
    logic            arst_n;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            commit;
    wb_req_t         wb;
    idu_out_t        out;
    logic            out_valid;

    // shadow state and expected output
    logic [xlen-1:0] gpr_m [32];
    logic [xlen-1:0] csr_m [4];
    idu_out_t        exp_next;
    idu_out_t        exp_hold;
    logic            commit_q;

    string           cur_test;
    int              errors;
    int              errors_at_start;
    int              tests_run;
    int              tests_failed;

    idu_ctrl_t       c;
    int unsigned     k;
    logic [4:0]      rd_i, rs1_i, rs2_i;
    logic [11:0]     imm12;
    logic [31:0]     r32;

    // alu table in the order add sub sll slt sltu xor srl sra or and
    logic [6:0] f7s [10] = '{f7_base, f7_alt, f7_base, f7_base, f7_base,
                              f7_base, f7_base, f7_alt, f7_base, f7_base};
    logic [2:0] f3s [10] = '{f3_add, f3_add, f3_sll, f3_slt, f3_sltu,
                              f3_xor, f3_sr, f3_sr, f3_or, f3_and};
    alu_op_e    ops [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                              alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    int unsigned imm_k [6] = '{0, 3, 4, 5, 8, 9};

    // tables for shifts, loads and branches
    int unsigned k_shift [3] = '{2, 6, 7};
    logic [2:0]  ld_f3 [5]   = '{f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu};
    mem_size_e   ld_size [5] = '{mem_byte, mem_half, mem_word, mem_byte_u, mem_half_u};
    logic [2:0]  br_f3 [6]   = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
    branch_e     br_kind [6] = '{br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu};
    alu_op_e     br_alu [6]  = '{alu_sub, alu_sub, alu_slt, alu_slt, alu_sltu, alu_sltu};

    idu_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc        (pc),
        .inst      (inst),
        .commit    (commit),
        .wb        (wb),
        .out       (out),
        .out_valid (out_valid)
    );

    always #5 clk = ~clk;

    // ========================================
    // reference model
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                gpr_m[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                csr_m[i] <= '0;
            end
            exp_hold <= '0;
            commit_q <= 1'b0;
        end else begin
            if (wb.gpr_wr && wb.rd != 5'd0) begin
                gpr_m[wb.rd] <= wb.gpr_data;
            end
            if (wb.csr_wr) begin
                csr_m[wb.csr_idx] <= wb.csr_data;
            end
            if (commit) begin
                exp_hold <= exp_next;
            end
            commit_q <= commit;
        end
    end

    function automatic logic [31:0] gpr_read(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wb.gpr_wr && wb.rd == idx) begin
            return wb.gpr_data;
        end
        return gpr_m[idx];
    endfunction

    function automatic logic [31:0] csr_read(input csr_idx_e idx);
        if (wb.csr_wr && wb.csr_idx == idx) begin
            return wb.csr_data;
        end
        return csr_m[idx];
    endfunction

    function automatic idu_out_t expect_out(input logic [31:0] p, input logic [31:0] w,
                                            input idu_ctrl_t cc, input logic [31:0] im);
        idu_out_t   o;
        logic [6:0] opc;
        o   = '0;
        opc = w[6:0];
        o.pc   = p;
        o.inst = w;
        o.rd   = w[11:7];
        // u-type, jal and ecall/ebreak have no rs1 field
        if (!(opc == opc_lui || opc == opc_auipc || opc == opc_jal ||
              (opc == opc_system && w[14:12] == f3_priv))) begin
            o.rs1 = w[19:15];
        end
        if (opc == opc_op || opc == opc_branch || opc == opc_store) begin
            o.rs2 = w[24:20];
        end
        o.imm      = im;
        o.rs1_data = gpr_read(o.rs1);
        o.rs2_data = gpr_read(o.rs2);
        o.csr_data = csr_read(cc.csr_idx);
        o.ctrl     = cc;
        return o;
    endfunction

    // ========================================
    // checking
    a_out_match: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> out == exp_hold)
    else begin
        errors++;
        $display("CHECK FAILED test=%s expected=%h actual=%h",
                 cur_test, $sampled(exp_hold), $sampled(out));
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == commit_q)
    else begin
        errors++;
        $display("CHECK FAILED test=%s out_valid expected=%b actual=%b",
                 cur_test, $sampled(commit_q), $sampled(out_valid));
    end

    // ========================================
    // encoders and helpers
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] s2,
                                          input logic [4:0] s1, input logic [2:0] f3,
                                          input logic [4:0] d, input logic [6:0] opc);
        return {f7, s2, s1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] im, input logic [4:0] s1,
                                          input logic [2:0] f3, input logic [4:0] d,
                                          input logic [6:0] opc);
        return {im, s1, f3, d, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] im, input logic [4:0] s2,
                                          input logic [4:0] s1, input logic [2:0] f3);
        return {im[11:5], s2, s1, f3, im[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] im, input logic [4:0] s2,
                                          input logic [4:0] s1, input logic [2:0] f3);
        return {im[12], im[10:5], s2, s1, f3, im[4:1], im[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] im, input logic [4:0] d);
        return {im[20], im[10:1], im[11], im[19:12], d, opc_jal};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [4:0] rnd5();
        logic [31:0] r;
        r = $urandom;
        return r[4:0];
    endfunction

    function automatic logic [11:0] rnd12();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    function automatic logic [11:0] csr_addr_of(input int unsigned i);
        case (i)
            0:       return csr_addr_mstatus;
            1:       return csr_addr_mtvec;
            2:       return csr_addr_mepc;
            default: return csr_addr_mcause;
        endcase
    endfunction

    function automatic idu_ctrl_t alu_ctrl(input alu_op_e op, input logic use_imm);
        idu_ctrl_t cc;
        cc           = '0;
        cc.alu_op    = op;
        cc.alu_src2  = use_imm ? src2_imm : src2_rs2;
        cc.write_gpr = 1'b1;
        return cc;
    endfunction

    function automatic idu_ctrl_t csr_ctrl(input int unsigned i, input logic set);
        idu_ctrl_t cc;
        cc           = '0;
        cc.csrrw     = !set;
        cc.csrrs     = set;
        cc.alu_op    = set ? alu_or : alu_add;
        cc.alu_src2  = src2_csr;
        cc.csr_idx   = csr_idx_e'(i[1:0]);
        cc.write_gpr = 1'b1;
        cc.write_csr = 1'b1;
        return cc;
    endfunction

    // commit stays high so consecutive calls run back to back
    task automatic issue(input logic [31:0] w, input idu_ctrl_t cc, input logic [31:0] im);
        pc       = $urandom & 32'hffff_fffc;
        inst     = w;
        commit   = 1'b1;
        exp_next = expect_out(pc, w, cc, im);
        @(negedge clk);
    endtask

    task automatic idle();
        commit = 1'b0;
        wb     = '0;
        @(negedge clk);
    endtask

    task automatic random_wb(input logic [4:0] near);
        r32         = $urandom;
        wb          = '0;
        wb.gpr_wr   = r32[0];
        wb.rd       = r32[1] ? near : rnd5();
        wb.gpr_data = $urandom;
    endtask

    task automatic finish_test();
        idle();
        idle();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", cur_test, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // ========================================
    // stimulus
    initial begin
        void'($urandom(32'h1b70_c87a));
        arst_n = 1'b0;
        pc     = '0;
        inst   = '0;
        commit = 1'b0;
        wb     = '0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        cur_test = "reset";
        assert (out == '0 && !out_valid) else begin
            errors++;
            $display("CHECK FAILED test=reset expected=0 actual=%h valid=%b", out, out_valid);
        end
        for (int i = 0; i < 32; i++) begin
            issue(enc_r(f7_base, 5'(i), 5'(i), f3_add, 5'd1, opc_op), alu_ctrl(alu_add, 0), '0);
        end
        for (int unsigned i = 0; i < 4; i++) begin
            issue(enc_i(csr_addr_of(i), 5'd0, f3_csrrs, 5'd2, opc_system), csr_ctrl(i, 1),
                  {20'b0, csr_addr_of(i)});
        end
        finish_test();

        cur_test = "gpr_file";
        repeat (20) begin
            wb          = '0;
            wb.gpr_wr   = 1'b1;
            wb.rd       = rnd5();
            wb.gpr_data = $urandom;
            @(negedge clk);
        end
        // write to x0 must not show
        wb          = '0;
        wb.gpr_wr   = 1'b1;
        wb.gpr_data = $urandom;
        issue(enc_r(f7_base, 5'd0, 5'd0, f3_add, 5'd3, opc_op), alu_ctrl(alu_add, 0), '0);
        repeat (16) begin
            k     = $urandom_range(9, 0);
            rd_i  = rnd5();
            rs1_i = rnd5();
            rs2_i = rnd5();
            random_wb(rs1_i);
            issue(enc_r(f7s[k], rs2_i, rs1_i, f3s[k], rd_i, opc_op), alu_ctrl(ops[k], 0), '0);
            k     = imm_k[$urandom_range(5, 0)];
            imm12 = rnd12();
            random_wb(rs1_i);
            issue(enc_i(imm12, rs1_i, f3s[k], rd_i, opc_op_imm), alu_ctrl(ops[k], 1),
                  sext12(imm12));
        end
        finish_test();

        cur_test = "alu_imm";
        for (int unsigned i = 0; i < 10; i++) begin
            issue(enc_r(f7s[i], rnd5(), rnd5(), f3s[i], rnd5(), opc_op), alu_ctrl(ops[i], 0), '0);
        end
        foreach (imm_k[i]) begin
            imm12 = rnd12();
            issue(enc_i(imm12, rnd5(), f3s[imm_k[i]], rnd5(), opc_op_imm),
                  alu_ctrl(ops[imm_k[i]], 1), sext12(imm12));
        end
        // shifts carry funct7 in the upper immediate bits
        foreach (k_shift[i]) begin
            imm12 = {f7s[k_shift[i]], rnd5()};
            issue(enc_i(imm12, rnd5(), f3s[k_shift[i]], rnd5(), opc_op_imm),
                  alu_ctrl(ops[k_shift[i]], 1), sext12(imm12));
        end
        r32 = $urandom;
        c   = alu_ctrl(alu_add, 1);
        issue({r32[31:12], rnd5(), opc_lui}, c, {r32[31:12], 12'b0});
        c.alu_src1 = src1_pc;
        issue({r32[31:12], rnd5(), opc_auipc}, c, {r32[31:12], 12'b0});
        c           = alu_ctrl(alu_add, 0);
        c.alu_src1  = src1_pc;
        c.alu_src2  = src2_four;
        c.branch    = br_jump;
        c.jump_base = jb_pc;
        r32         = $urandom & 32'h001f_fffe;
        issue(enc_j(r32[20:0], rnd5()), c, {{11{r32[20]}}, r32[20:0]});
        c.jump_base = jb_rs1;
        imm12       = rnd12();
        issue(enc_i(imm12, rnd5(), 3'b000, rnd5(), opc_jalr), c, sext12(imm12));
        foreach (ld_f3[i]) begin
            c            = alu_ctrl(alu_add, 1);
            c.mem_to_reg = 1'b1;
            c.mem_size   = ld_size[i];
            imm12        = rnd12();
            issue(enc_i(imm12, rnd5(), ld_f3[i], rnd5(), opc_load), c, sext12(imm12));
        end
        for (int i = 0; i < 3; i++) begin
            c           = '0;
            c.alu_src2  = src2_imm;
            c.write_mem = 1'b1;
            c.mem_size  = ld_size[i];
            imm12       = rnd12();
            issue(enc_s(imm12, rnd5(), rnd5(), ld_f3[i]), c, sext12(imm12));
        end
        finish_test();

        cur_test = "branch";
        foreach (br_f3[i]) begin
            c        = '0;
            c.branch = br_kind[i];
            c.alu_op = br_alu[i];
            r32      = $urandom & 32'h0000_1ffe;
            issue(enc_b(r32[12:0], rnd5(), rnd5(), br_f3[i]), c, {{19{r32[12]}}, r32[12:0]});
        end
        finish_test();

        cur_test = "csr";
        for (int unsigned i = 0; i < 4; i++) begin
            wb          = '0;
            wb.csr_wr   = 1'b1;
            wb.csr_idx  = csr_idx_e'(i[1:0]);
            wb.csr_data = $urandom;
            @(negedge clk);
        end
        wb = '0;
        for (int unsigned i = 0; i < 4; i++) begin
            issue(enc_i(csr_addr_of(i), rnd5(), f3_csrrw, rnd5(), opc_system), csr_ctrl(i, 0),
                  {20'b0, csr_addr_of(i)});
            // same-cycle csr write-back goes through the bypass
            wb.csr_wr   = 1'b1;
            wb.csr_idx  = csr_idx_e'(i[1:0]);
            wb.csr_data = $urandom;
            issue(enc_i(csr_addr_of(i), rnd5(), f3_csrrs, rnd5(), opc_system), csr_ctrl(i, 1),
                  {20'b0, csr_addr_of(i)});
            wb = '0;
        end
        c           = '0;
        c.csrrw     = 1'b1;
        c.alu_src2  = src2_csr;
        c.illegal   = 1'b1;
        rs1_i       = rnd5();
        issue(enc_i(12'h7c0, rs1_i, f3_csrrw, rnd5(), opc_system), c, 32'h0000_07c0);
        c           = '0;
        c.ecall     = 1'b1;
        c.branch    = br_jump;
        c.jump_base = jb_csr;
        c.csr_idx   = csr_mtvec;
        issue(enc_i(f12_ecall, 5'd0, f3_priv, 5'd0, opc_system), c, '0);
        c           = '0;
        c.halt      = 1'b1;
        issue(enc_i(f12_ebreak, 5'd0, f3_priv, 5'd0, opc_system), c, 32'd1);
        finish_test();

        cur_test = "back_to_back";
        repeat (8) begin
            k = $urandom_range(9, 0);
            issue(enc_r(f7s[k], rnd5(), rnd5(), f3s[k], rnd5(), opc_op), alu_ctrl(ops[k], 0), '0);
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog timeout, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== idu_top.f ====
rtl/rv_isa_pkg.sv
rtl/idu_pkg.sv
rtl/idu_decode.sv
rtl/idu_gpr_file.sv
rtl/idu_csr_file.sv
rtl/idu_stage_reg.sv
rtl/idu_top.sv
tb/idu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f idu_top.f \
    --top-module idu_tb \
    --Mdir obj_dir \
    -o idu_sim

./obj_dir/idu_sim | tee sim.log

grep -q "Simulation passed" sim.log
